//--- source/cqt_pkg.sv
// ==========================================================================
// shared sizes and types for the coding quadtree decoder, 64x64 CTB with
// 8x8 minimum CU; picture dimensions must be multiples of 8 pixels
// ==========================================================================
package cqt_pkg;

    localparam int CTB_LOG2    = 6;
    localparam int MIN_CU_LOG2 = 3;
    localparam int MAX_DEPTH   = CTB_LOG2 - MIN_CU_LOG2;  // no flag is decoded here
    localparam int GRID        = 1 << MAX_DEPTH;          // 8x8 units per CTB side

    // split_cu_flag contexts sit at base, base+1 and base+2
    localparam logic [9:0] SPLIT_CTX_BASE = 10'd4;

    typedef logic [9:0] ctx_addr_t;

    // pixel coordinates, up to 4096x2048 pictures
    typedef logic [11:0] pix_x_t;
    typedef logic [10:0] pix_y_t;

    typedef logic [5:0] ctb_col_t;
    typedef logic [4:0] ctb_row_t;

    typedef logic [1:0] depth_t;
    typedef logic [2:0] grid_t;  // 8x8 unit index inside the CTB

    typedef enum logic [2:0] {
        IDLE,
        EVAL,
        BIN_WAIT,
        LEAF,
        NEXT,
        FINISH
    } walk_state_t;

endpackage

//--- source/cqt_walker.sv
// ==========================================================================
// z-order quadtree walker; ctb_x/ctb_y and picture size must be held while
// busy, and only one bin request is ever outstanding
// ==========================================================================
`timescale 1ns/1ns

module cqt_walker
    import cqt_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  logic        cqt_start,
    input  ctb_col_t    ctb_x,
    input  ctb_row_t    ctb_y,
    input  pix_x_t      pic_width,
    input  pix_y_t      pic_height,

    input  ctx_addr_t   ctx_addr,
    output logic        bin_req,
    input  logic        bin,
    input  logic        bin_vld,

    output logic        cu_valid,
    input  logic        cu_ready,
    output pix_x_t      cu_x,
    output pix_y_t      cu_y,
    output logic [2:0]  cu_log2_size,

    output grid_t       node_x,
    output grid_t       node_y,
    output depth_t      node_depth,
    output logic        leaf_wr,
    output logic        ctb_end,
    output logic        busy,
    output logic        ctb_done
);

    walk_state_t state, nxt_state;

    depth_t      depth;
    depth_t      child_depth;
    logic [1:0]  zidx [1:MAX_DEPTH];  // z-order position among siblings at each level

    depth_t      step_depth;
    logic        step_done;

    logic [12:0] end_x;
    logic [11:0] end_y;
    logic        fits;
    logic        origin_in;
    logic        at_min;
    logic        ask_bin;
    logic        force_split;
    logic        skip;
    logic        descend;
    logic        advance;

    // node origin from the per-level indices where bit 0 of a z index is x
    always_comb begin
        node_x = '0;
        node_y = '0;
        for (int k = 1; k <= MAX_DEPTH; k++) begin
            if (k <= int'(depth)) begin
                node_x[MAX_DEPTH-k] = zidx[k][0];
                node_y[MAX_DEPTH-k] = zidx[k][1];
            end
        end
    end

    assign node_depth   = depth;
    assign child_depth  = depth + 1'b1;
    assign cu_log2_size = 3'(CTB_LOG2) - 3'(depth);
    assign cu_x         = {ctb_x, node_x, {MIN_CU_LOG2{1'b0}}};
    assign cu_y         = {ctb_y, node_y, {MIN_CU_LOG2{1'b0}}};

    assign end_x     = {1'b0, cu_x} + (13'd1 << cu_log2_size);
    assign end_y     = {1'b0, cu_y} + (12'd1 << cu_log2_size);
    assign fits      = (end_x <= {1'b0, pic_width}) && (end_y <= {1'b0, pic_height});
    assign origin_in = (cu_x < pic_width) && (cu_y < pic_height);

    assign at_min      = (depth == depth_t'(MAX_DEPTH));
    assign ask_bin     = fits && !at_min;
    assign force_split = !fits && !at_min;  // straddles the right or bottom edge
    assign skip        = at_min && !origin_in;

    // deepest level that still has a sibling left; none means the CTB is done
    always_comb begin
        step_depth = '0;
        step_done  = 1'b1;
        for (int k = 1; k <= MAX_DEPTH; k++) begin
            if (k <= int'(depth) && zidx[k] != 2'd3) begin
                step_depth = depth_t'(k);
                step_done  = 1'b0;
            end
        end
    end

    assign descend = (state == EVAL && force_split) ||
                     (state == BIN_WAIT && bin_vld && bin);
    assign advance = (state == EVAL && skip) ||
                     (state == LEAF && cu_ready);

    always_comb begin
        nxt_state = state;
        case (state)
            IDLE:     if (cqt_start) nxt_state = NEXT;
            NEXT:     nxt_state = EVAL;
            EVAL: begin
                if (ask_bin)
                    nxt_state = BIN_WAIT;
                else if (force_split)
                    nxt_state = NEXT;
                else if (skip)
                    nxt_state = step_done ? FINISH : NEXT;
                else
                    nxt_state = LEAF;
            end
            BIN_WAIT: if (bin_vld) nxt_state = bin ? NEXT : LEAF;
            LEAF:     if (cu_ready) nxt_state = step_done ? FINISH : NEXT;
            FINISH:   nxt_state = IDLE;
            default:  nxt_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= nxt_state;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            depth <= '0;
            for (int k = 1; k <= MAX_DEPTH; k++)
                zidx[k] <= '0;
        end else if (state == IDLE && cqt_start) begin
            depth <= '0;  // root covers the whole CTB
        end else if (descend) begin
            depth             <= child_depth;
            zidx[child_depth] <= '0;
        end else if (advance && !step_done) begin
            depth            <= step_depth;  // climbs as many levels as needed
            zidx[step_depth] <= zidx[step_depth] + 1'b1;
        end
    end

    // ctx_addr is registered by the context stage one cycle after NEXT
    assign bin_req  = (state == EVAL) && ask_bin;
    assign cu_valid = (state == LEAF);
    assign leaf_wr  = (state == EVAL && !ask_bin && !force_split && !skip) ||
                      (state == BIN_WAIT && bin_vld && !bin);
    assign ctb_end  = (state == FINISH);
    assign ctb_done = (state == FINISH);
    assign busy     = (state != IDLE);

endmodule

//--- source/cqt_ctx_select.sv
// ==========================================================================
// split_cu_flag context from left and above neighbour depths; a picture
// is one slice, so only picture column 0 and row 0 make a neighbour absent
// ==========================================================================
`timescale 1ns/1ns

module cqt_ctx_select
    import cqt_pkg::*;
(
    input  logic      clk,

    input  grid_t     node_x,
    input  grid_t     node_y,
    input  depth_t    node_depth,
    input  ctb_col_t  ctb_x,
    input  ctb_row_t  ctb_y,

    output grid_t     left_x,
    output grid_t     above_y,
    output logic      left_from_buf,
    output logic      above_from_buf,
    input  depth_t    left_depth,
    input  depth_t    above_depth,

    output ctx_addr_t ctx_addr
);

    logic left_avail;
    logic above_avail;
    logic cond_l;
    logic cond_a;

    // neighbour unit left of the node origin
    always_comb begin
        left_x        = node_x - 1'b1;
        left_from_buf = (node_x == '0);  // previous CTB in the row
        left_avail    = !(left_from_buf && ctb_x == '0);
    end

    // neighbour unit above the node origin
    always_comb begin
        above_y        = node_y - 1'b1;
        above_from_buf = (node_y == '0);  // bottom row of the CTB above
        above_avail    = !(above_from_buf && ctb_y == '0);
    end

    assign cond_l = left_avail && (left_depth > node_depth);
    assign cond_a = above_avail && (above_depth > node_depth);

    always_ff @(posedge clk) begin
        ctx_addr <= SPLIT_CTX_BASE + ctx_addr_t'(cond_l) + ctx_addr_t'(cond_a);
    end

endmodule

//--- source/cqt_edge_store.sv
// ==========================================================================
// depth map of the current CTB plus left column and above row buffers;
// CTBs arrive in raster order and ctb_x stays below MAX_CTB_COLS
// ==========================================================================
`timescale 1ns/1ns

module cqt_edge_store
    import cqt_pkg::*;
#(
    parameter int MAX_CTB_COLS = 64
) (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     leaf_wr,
    input  grid_t    node_x,
    input  grid_t    node_y,
    input  depth_t   node_depth,

    input  logic     ctb_end,
    input  ctb_col_t ctb_x,

    input  grid_t    left_x,
    input  grid_t    above_y,
    input  logic     left_from_buf,
    input  logic     above_from_buf,
    output depth_t   left_depth,
    output depth_t   above_depth
);

    depth_t depth_map [GRID][GRID];          // [y][x] in 8x8 units
    depth_t left_buf  [GRID];                // right column of the previous CTB
    depth_t above_buf [MAX_CTB_COLS][GRID];  // bottom row, one entry per CTB column

    logic                    left_vld;
    logic [MAX_CTB_COLS-1:0] above_vld;

    logic [3:0]      span;
    logic [GRID-1:0] cover_x;
    logic [GRID-1:0] cover_y;

    // units covered by the leaf being written
    assign span = 4'(GRID) >> node_depth;

    always_comb begin
        for (int i = 0; i < GRID; i++) begin
            cover_x[i] = (4'(i) >= {1'b0, node_x}) && (4'(i) < {1'b0, node_x} + span);
            cover_y[i] = (4'(i) >= {1'b0, node_y}) && (4'(i) < {1'b0, node_y} + span);
        end
    end

    always_ff @(posedge clk) begin
        if (leaf_wr) begin
            for (int y = 0; y < GRID; y++) begin
                for (int x = 0; x < GRID; x++) begin
                    if (cover_x[x] && cover_y[y])
                        depth_map[y][x] <= node_depth;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctb_end) begin
            for (int i = 0; i < GRID; i++) begin
                left_buf[i]         <= depth_map[i][GRID-1];
                above_buf[ctb_x][i] <= depth_map[GRID-1][i];
            end
        end
    end

    // buffers hold nothing useful until the first CTB has ended
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            left_vld  <= 1'b0;
            above_vld <= '0;
        end else if (ctb_end) begin
            left_vld         <= 1'b1;
            above_vld[ctb_x] <= 1'b1;
        end
    end

    always_comb begin
        if (left_from_buf)
            left_depth = left_vld ? left_buf[node_y] : '0;
        else
            left_depth = depth_map[node_y][left_x];
    end

    always_comb begin
        if (above_from_buf)
            above_depth = above_vld[ctb_x] ? above_buf[ctb_x][node_x] : '0;
        else
            above_depth = depth_map[above_y][node_x];
    end

endmodule

//--- source/cqt_decoder.sv
// ==========================================================================
// coding quadtree decoder top; bins come from an external arithmetic
// decoder, leaf CUs leave on a valid/ready port
// ==========================================================================
`timescale 1ns/1ns

module cqt_decoder
    import cqt_pkg::*;
#(
    parameter int MAX_CTB_COLS = 64  // widest picture in CTBs
) (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        cqt_start,
    input  ctb_col_t    ctb_x,
    input  ctb_row_t    ctb_y,
    input  pix_x_t      pic_width,
    input  pix_y_t      pic_height,

    output logic        bin_req,
    output ctx_addr_t   ctx_addr,
    input  logic        bin,
    input  logic        bin_vld,

    output logic        cu_valid,
    input  logic        cu_ready,
    output pix_x_t      cu_x,
    output pix_y_t      cu_y,
    output logic [2:0]  cu_log2_size,

    output logic        busy,
    output logic        ctb_done
);

    grid_t  node_x;
    grid_t  node_y;
    depth_t node_depth;
    logic   leaf_wr;
    logic   ctb_end;
    grid_t  left_x;
    grid_t  above_y;
    logic   left_from_buf;
    logic   above_from_buf;
    depth_t left_depth;
    depth_t above_depth;

    cqt_walker u_cqt_walker (
        .clk,
        .rst_n,
        .cqt_start,
        .ctb_x,
        .ctb_y,
        .pic_width,
        .pic_height,
        .ctx_addr,
        .bin_req,
        .bin,
        .bin_vld,
        .cu_valid,
        .cu_ready,
        .cu_x,
        .cu_y,
        .cu_log2_size,
        .node_x,
        .node_y,
        .node_depth,
        .leaf_wr,
        .ctb_end,
        .busy,
        .ctb_done
    );

    cqt_ctx_select u_cqt_ctx_select (
        .clk,
        .node_x,
        .node_y,
        .node_depth,
        .ctb_x,
        .ctb_y,
        .left_x,
        .above_y,
        .left_from_buf,
        .above_from_buf,
        .left_depth,
        .above_depth,
        .ctx_addr
    );

    cqt_edge_store #(
        .MAX_CTB_COLS (MAX_CTB_COLS)
    ) u_cqt_edge_store (
        .clk,
        .rst_n,
        .leaf_wr,
        .node_x,
        .node_y,
        .node_depth,
        .ctb_end,
        .ctb_x,
        .left_x,
        .above_y,
        .left_from_buf,
        .above_from_buf,
        .left_depth,
        .above_depth
    );

endmodule

//--- test/cqt_assert.sv
// ==========================================================================
// handshake checks on the walker ports, bound into cqt_walker; nothing is
// checked while rst_n is low
// ==========================================================================
`timescale 1ns/1ns

module cqt_assert
    import cqt_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       bin_req,
    input logic       bin_vld,
    input logic       cu_valid,
    input logic       cu_ready,
    input pix_x_t     cu_x,
    input pix_y_t     cu_y,
    input logic [2:0] cu_log2_size,
    input logic       ctb_done
);

    int   cu_fails   = 0;
    int   bin_fails  = 0;
    int   done_fails = 0;
    logic bin_pending;  // request sent, answer not yet seen

    always_ff @(posedge clk) begin
        if (!rst_n)
            bin_pending <= 1'b0;
        else if (bin_req)
            bin_pending <= 1'b1;
        else if (bin_vld)
            bin_pending <= 1'b0;
    end

    cu_hold: assert property (@(posedge clk) disable iff (!rst_n)
        cu_valid && !cu_ready |=> cu_valid && $stable(cu_x) && $stable(cu_y)
                                  && $stable(cu_log2_size))
        else begin
            $error("CU output changed before it was accepted");
            cu_fails++;
        end

    bin_single: assert property (@(posedge clk) disable iff (!rst_n)
        bin_req |-> !bin_pending)
        else begin
            $error("bin request issued while another is outstanding");
            bin_fails++;
        end

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        ctb_done |=> !ctb_done)
        else begin
            $error("ctb_done held for more than one cycle");
            done_fails++;
        end

endmodule

bind cqt_walker cqt_assert u_cqt_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .bin_req      (bin_req),
    .bin_vld      (bin_vld),
    .cu_valid     (cu_valid),
    .cu_ready     (cu_ready),
    .cu_x         (cu_x),
    .cu_y         (cu_y),
    .cu_log2_size (cu_log2_size),
    .ctb_done     (ctb_done)
);

//--- test/cqt_tb.sv
// ==========================================================================
// testbench for cqt_decoder; each picture is decoded in raster order from
// CTB (0,0), with behavioural bin decoder and CU sink models
// ==========================================================================
`timescale 1ns/1ns

module cqt_tb
    import cqt_pkg::*;
();

    localparam int DRIVE_DLY      = 2;
    localparam int MAX_CTB_COLS   = 64;
    localparam int NUM_CTBS       = 27;  // 1 + 4 + 12 + 6 + 4
    localparam int NODE_WORST     = 12;  // 2 walk cycles, 4 bin, 4 sink, slack
    localparam int TIMEOUT_CYCLES = NUM_CTBS * (85 * NODE_WORST + 8) + 200;

    logic       clk;
    logic       rst_n;
    logic       cqt_start;
    ctb_col_t   ctb_x;
    ctb_row_t   ctb_y;
    pix_x_t     pic_width;
    pix_y_t     pic_height;
    logic       bin_req;
    ctx_addr_t  ctx_addr;
    logic       bin;
    logic       bin_vld;
    logic       cu_valid;
    logic       cu_ready;
    pix_x_t     cu_x;
    pix_y_t     cu_y;
    logic [2:0] cu_log2_size;
    logic       busy;
    logic       ctb_done;

    ctx_addr_t  exp_ctx [$];
    pix_x_t     exp_cu_x [$];
    pix_y_t     exp_cu_y [$];
    logic [2:0] exp_cu_size [$];
    logic       bin_q [$];      // bins the model consumed for the bin decoder to replay
    logic       exp_last_leaf;  // last z-order node of the CTB is a CU

    int   unit_depth [64][32];  // model depth per 8x8 unit indexed [column][row]
    int   pic_w;
    int   pic_h;
    int   cycle;
    int   errors;
    int   tests;
    int   req_count;
    int   cu_count;
    int   last_xfer_cycle;
    logic ready_random;

    cqt_decoder #(
        .MAX_CTB_COLS (MAX_CTB_COLS)
    ) u_cqt_decoder (
        .clk, .rst_n, .cqt_start, .ctb_x, .ctb_y, .pic_width, .pic_height,
        .bin_req, .ctx_addr, .bin, .bin_vld,
        .cu_valid, .cu_ready, .cu_x, .cu_y, .cu_log2_size,
        .busy, .ctb_done
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // walks the quadtree of one CTB in z-order on a node stack
    function automatic void model_ctb(input int col, input int row, input logic random_bins);
        int   sx [16];
        int   sy [16];
        int   sd [16];
        int   sp;
        int   x0;
        int   y0;
        int   d;
        int   size;
        int   ctx;
        logic fits;
        logic split;
        logic leaf;
        logic b;
        sx[0] = col * 64;
        sy[0] = row * 64;
        sd[0] = 0;
        sp    = 1;
        while (sp > 0) begin
            sp--;
            x0    = sx[sp];
            y0    = sy[sp];
            d     = sd[sp];
            size  = 64 >> d;
            fits  = (x0 + size <= pic_w) && (y0 + size <= pic_h);
            split = 1'b0;
            leaf  = 1'b0;
            if (d < MAX_DEPTH && fits) begin
                ctx = int'(SPLIT_CTX_BASE);
                if (x0 > 0 && unit_depth[x0 / 8 - 1][y0 / 8] > d)
                    ctx++;
                if (y0 > 0 && unit_depth[x0 / 8][y0 / 8 - 1] > d)
                    ctx++;
                exp_ctx.push_back(ctx_addr_t'(ctx));
                b = random_bins && (($urandom % 3) != 0);  // splits two times in three
                bin_q.push_back(b);
                split = b;
                leaf  = !b;
            end else if (d < MAX_DEPTH) begin
                split = 1'b1;  // straddles the picture edge
            end else begin
                leaf = (x0 < pic_w) && (y0 < pic_h);
            end
            if (split) begin
                for (int k = 3; k >= 0; k--) begin
                    sx[sp] = x0 + (k % 2) * (size / 2);
                    sy[sp] = y0 + (k / 2) * (size / 2);
                    sd[sp] = d + 1;
                    sp++;
                end
            end else begin
                exp_last_leaf = leaf;
                if (leaf) begin
                    exp_cu_x.push_back(pix_x_t'(x0));
                    exp_cu_y.push_back(pix_y_t'(y0));
                    exp_cu_size.push_back(3'(6 - d));
                    for (int ux = x0 / 8; ux < (x0 + size) / 8; ux++) begin
                        for (int uy = y0 / 8; uy < (y0 + size) / 8; uy++)
                            unit_depth[ux][uy] = d;
                    end
                end
            end
        end
    endfunction

    task automatic check_ctx(input ctx_addr_t got, input ctx_addr_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: ctx_addr is %0d, expected %0d", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_cu(input pix_x_t got_x, input pix_x_t exp_x,
                            input pix_y_t got_y, input pix_y_t exp_y,
                            input logic [2:0] got_size, input logic [2:0] exp_size);
        if (got_x !== exp_x) begin
            $display("Error at %0t ns: cu_x is %0d, expected %0d", $time, got_x, exp_x);
            errors++;
        end
        if (got_y !== exp_y) begin
            $display("Error at %0t ns: cu_y is %0d, expected %0d", $time, got_y, exp_y);
            errors++;
        end
        if (got_size !== exp_size) begin
            $display("Error at %0t ns: cu_log2_size is %0d, expected %0d",
                     $time, got_size, exp_size);
            errors++;
        end
    endtask

    task automatic check_busy(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t ns: busy is %0b, expected %0b", $time, got, exp);
            errors++;
        end
    endtask

    // compares requests and transfers against the model at mid-cycle
    always @(negedge clk) begin
        if (rst_n && bin_req) begin
            req_count++;
            if (exp_ctx.size() == 0) begin
                $display("bin request at %0t ns where no split flag is due", $time);
                errors++;
            end else begin
                check_ctx(ctx_addr, exp_ctx.pop_front());
            end
        end
        if (rst_n && cu_valid && cu_ready) begin
            cu_count++;
            last_xfer_cycle = cycle;
            if (exp_cu_x.size() == 0) begin
                $display("CU transfer at %0t ns where no CU is due", $time);
                errors++;
            end else begin
                check_cu(cu_x, exp_cu_x.pop_front(), cu_y, exp_cu_y.pop_front(),
                         cu_log2_size, exp_cu_size.pop_front());
            end
        end
    end

    // bin decoder answering 1 to 4 cycles after each request
    initial begin
        int delay;
        forever begin
            @(negedge clk);
            if (bin_req) begin
                delay = 1 + int'($urandom % 4);
                repeat (delay) @(posedge clk);
                #DRIVE_DLY;
                if (bin_q.size() == 0) begin
                    $display("bin decoder has no bin left for the request");
                    errors++;
                    bin = 1'b0;
                end else begin
                    bin = bin_q.pop_front();
                end
                bin_vld = 1'b1;
                @(posedge clk);
                #DRIVE_DLY;
                bin_vld = 1'b0;
            end
        end
    end

    // CU sink that is never low for more than 3 cycles in a row
    initial begin
        int low_run;
        low_run = 0;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            if (ready_random && low_run < 3 && ($urandom % 2) == 0) begin
                cu_ready = 1'b0;
                low_run++;
            end else begin
                cu_ready = 1'b1;
                low_run  = 0;
            end
        end
    end

    initial begin
        cycle = 0;
        while (cycle < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle++;
        end
        $display("timeout after %0d cycles, the decoder stopped making progress", cycle);
        $display("Checks failed");
        $finish;
    end

    task automatic run_ctb(input int col, input int row, input logic random_bins);
        model_ctb(col, row, random_bins);
        @(posedge clk);
        #DRIVE_DLY;
        check_busy(busy, 1'b0);
        ctb_x     = ctb_col_t'(col);
        ctb_y     = ctb_row_t'(row);
        cqt_start = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        check_busy(busy, 1'b1);
        cqt_start = 1'b0;
        do
            @(negedge clk);
        while (!ctb_done);
        if (exp_last_leaf && cycle != last_xfer_cycle + 1) begin
            $display("ctb_done of CTB (%0d,%0d) did not follow the last CU by one cycle",
                     col, row);
            errors++;
        end
        if (exp_ctx.size() != 0 || exp_cu_x.size() != 0 || bin_q.size() != 0) begin
            $display("CTB (%0d,%0d) ended with %0d requests and %0d CUs still missing",
                     col, row, exp_ctx.size(), exp_cu_x.size());
            errors++;
            exp_ctx.delete();
            exp_cu_x.delete();
            exp_cu_y.delete();
            exp_cu_size.delete();
            bin_q.delete();
        end
    endtask

    task automatic run_picture(input string name, input int width, input int height,
                               input logic random_bins, input logic random_ready);
        int errors_before;
        errors_before = errors;
        @(posedge clk);
        #DRIVE_DLY;
        pic_w         = width;
        pic_h         = height;
        pic_width     = pix_x_t'(width);
        pic_height    = pix_y_t'(height);
        ready_random  = random_ready;
        for (int r = 0; r < (height + 63) / 64; r++) begin
            for (int c = 0; c < (width + 63) / 64; c++)
                run_ctb(c, r, random_bins);
        end
        ready_random = 1'b0;
        tests++;
        if (errors == errors_before)
            $display("test %0d %s %0dx%0d: ok", tests, name, width, height);
        else
            $display("test %0d %s %0dx%0d: %0d errors", tests, name, width, height,
                     errors - errors_before);
    endtask

    initial begin
        void'($urandom(32'h92da8bfa));
        errors       = 0;
        tests        = 0;
        req_count    = 0;
        cu_count     = 0;
        ready_random = 1'b0;
        rst_n        = 1'b0;
        cqt_start    = 1'b0;
        ctb_x        = '0;
        ctb_y        = '0;
        pic_width    = 12'd64;
        pic_height   = 11'd64;
        bin          = 1'b0;
        bin_vld      = 1'b0;
        cu_ready     = 1'b1;
        repeat (4) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        run_picture("single CTB, no split", 64, 64, 1'b0, 1'b0);
        run_picture("interior CTBs, random bins", 128, 128, 1'b1, 1'b0);
        run_picture("picture edges", 200, 136, 1'b1, 1'b0);
        run_picture("3x2 raster", 192, 128, 1'b1, 1'b0);
        run_picture("sink back-pressure", 128, 128, 1'b1, 1'b1);

        errors = errors + u_cqt_decoder.u_cqt_walker.u_cqt_assert.cu_fails
                        + u_cqt_decoder.u_cqt_walker.u_cqt_assert.bin_fails
                        + u_cqt_decoder.u_cqt_walker.u_cqt_assert.done_fails;
        $display("%0d tests, %0d bin requests, %0d CUs, %0d errors",
                 tests, req_count, cu_count, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
source/cqt_pkg.sv
source/cqt_walker.sv
source/cqt_ctx_select.sv
source/cqt_edge_store.sv
source/cqt_decoder.sv
test/cqt_assert.sv
test/cqt_tb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module cqt_tb -Mdir obj_dir -o cqt_sim -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cqt_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All checks passed" sim.log; then
    exit 0
fi
exit 1
